// ==== all.f ====
dcache_pkg.sv
dcache_tag_store.sv
dcache_line_store.sv
dcache_ctrl.sv
dcache_burst_port.sv
dcache_top.sv
burst_ram_model.sv
dcache_assertions.sv
tb_dcache.sv

// ==== burst_ram_model.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// behavioral 2 KB burst RAM
// four-beat bursts, read latency set per command
// ~~~~~~~~~~~~~~~~~~~~
module burst_ram_model #(
  parameter int DRIVE_DELAY = 10
) (
  input  logic                  clk,
  input  dcache_pkg::br_cmd_e   br_cmd,
  input  logic                  br_cmd_en,
  input  dcache_pkg::ram_addr_t br_addr,
  input  dcache_pkg::beat_t     br_wr_data,
  input  logic [2:0]            latency,
  output dcache_pkg::beat_t     br_rd_data,
  output logic                  br_rd_data_valid
);
  import dcache_pkg::*;

  localparam int DEPTH      = 2 ** RAM_ADDR_BITS;
  localparam int BEAT_BYTES = BEAT_BITS / 8;
  localparam int WORD_BYTES = WORD_BITS / 8;

  beat_t     mem [DEPTH];
  ram_addr_t wr_ptr;
  ram_addr_t rd_ptr;
  int        wr_left;
  int        rd_left;
  int        rd_wait;
  beat_t     next_data;
  logic      next_valid;

  initial begin
    // word at byte address a holds a ^ 5a5a0000
    for (int b = 0; b < DEPTH; b++) begin
      for (int w = 0; w < WORDS_PER_BEAT; w++) begin
        mem[b][w*WORD_BITS +: WORD_BITS] = word_t'(b*BEAT_BYTES + w*WORD_BYTES) ^ 32'h5a5a_0000;
      end
    end
    wr_left          = 0;
    rd_left          = 0;
    rd_wait          = 0;
    br_rd_data       = '0;
    br_rd_data_valid = 1'b0;
    forever begin
      @(posedge clk);
      next_valid = 1'b0;
      next_data  = '0;
      // beats 1 to 3 of a write follow the command back to back
      if (wr_left != 0) begin
        mem[wr_ptr] = br_wr_data;
        wr_ptr++;
        wr_left--;
      end
      // read beats go out once the latency has run down
      if (rd_left != 0) begin
        if (rd_wait != 0) begin
          rd_wait--;
        end else begin
          next_data  = mem[rd_ptr];
          next_valid = 1'b1;
          rd_ptr++;
          rd_left--;
        end
      end
      if (br_cmd_en === 1'b1) begin
        if (br_cmd == cmd_write) begin
          // beat 0 rides with the pulse
          mem[br_addr] = br_wr_data;
          wr_ptr       = br_addr + 1'b1;
          wr_left      = BEATS_PER_LINE - 1;
        end else begin
          rd_ptr  = br_addr;
          rd_wait = latency;
          rd_left = BEATS_PER_LINE;
        end
      end
      #DRIVE_DELAY;
      br_rd_data       = next_data;
      br_rd_data_valid = next_valid;
    end
  end

endmodule

// ==== dcache_assertions.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// cache protocol assertions, bound into dcache_top
// ~~~~~~~~~~~~~~~~~~~~
module dcache_assertions (
  input logic clk,
  input logic rst,
  input logic enable,
  input logic busy,
  input logic data_out_valid,
  input logic br_cmd_en
);

  // failed assertion count
  int fail_count = 0;

  // RAM command is a one-cycle pulse
  cmd_single_pulse: assert property (@(posedge clk) disable iff (rst) br_cmd_en |=> !br_cmd_en)
    else begin
      fail_count++;
      $error("br_cmd_en was high on two consecutive cycles");
    end

  // read data is never returned while a miss is still running
  valid_not_busy: assert property (@(posedge clk) disable iff (rst) data_out_valid |-> !busy)
    else begin
      fail_count++;
      $error("data_out_valid was high while busy was high");
    end

  // busy only rises after an accepted request
  busy_after_accept: assert property (@(posedge clk) disable iff (rst)
    $rose(busy) |-> $past(enable))
    else begin
      fail_count++;
      $error("busy rose without a request on the cycle before");
    end

  // outputs come out of reset idle
  idle_after_reset: assert property (@(posedge clk) rst |=> !busy && !data_out_valid && !br_cmd_en)
    else begin
      fail_count++;
      $error("busy, data_out_valid or br_cmd_en high on the cycle after reset");
    end

endmodule

bind dcache_top dcache_assertions assertions0 (
  .clk            (clk),
  .rst            (rst),
  .enable         (enable),
  .busy           (busy),
  .data_out_valid (data_out_valid),
  .br_cmd_en      (br_cmd_en)
);

// ==== dcache_burst_port.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// burst RAM port
// command pulse, line base address, write beats and beat counter
// ~~~~~~~~~~~~~~~~~~~~
module dcache_burst_port #(
  parameter int LINE_IX_BITS = 1,
  localparam int TAG_BITS = dcache_pkg::ADDR_BITS - LINE_IX_BITS
                          - dcache_pkg::WORD_IX_BITS - dcache_pkg::OFFSET_BITS
) (
  input  logic                  clk,
  input  logic                  rst,
  input  dcache_pkg::addr_t     address,
  input  logic [TAG_BITS-1:0]   victim_tag,
  input  logic                  start_write,
  input  logic                  start_read,
  input  dcache_pkg::beat_t     rd_beat,
  input  logic                  br_rd_data_valid,
  output dcache_pkg::beat_ix_t  beat_ix,
  output logic                  burst_done,
  output dcache_pkg::br_cmd_e   br_cmd,
  output logic                  br_cmd_en,
  output dcache_pkg::ram_addr_t br_addr,
  output dcache_pkg::beat_t     br_wr_data
);
  import dcache_pkg::*;

  // byte address to beat address
  localparam int BEAT_SHIFT = OFFSET_BITS + $clog2(WORDS_PER_BEAT);
  localparam beat_ix_t LAST_BEAT = beat_ix_t'(BEATS_PER_LINE - 1);

  logic [LINE_IX_BITS-1:0] line_ix;
  addr_t                   wb_base;
  addr_t                   rd_base;
  logic                    writing;
  logic                    reading;

  assign line_ix = address[OFFSET_BITS+WORD_IX_BITS +: LINE_IX_BITS];

  // victim line rebuilt from its stored tag, fetch line from the request
  assign wb_base = {victim_tag, line_ix, {(WORD_IX_BITS+OFFSET_BITS){1'b0}}};
  assign rd_base = {address[ADDR_BITS-1 -: TAG_BITS+LINE_IX_BITS],
                    {(WORD_IX_BITS+OFFSET_BITS){1'b0}}};

  // write beat comes straight from the line store at the current index
  assign br_wr_data = rd_beat;

  assign burst_done = (beat_ix == LAST_BEAT) && (writing || (reading && br_rd_data_valid));

  always_ff @(posedge clk) begin
    if (rst) begin
      br_cmd_en <= 1'b0;
      br_cmd    <= cmd_read;
      writing   <= 1'b0;
      reading   <= 1'b0;
      beat_ix   <= '0;
    end else begin
      br_cmd_en <= start_write || start_read;
      // RAM never stalls, write beats go out back to back
      if (writing) begin
        beat_ix <= beat_ix + 1'b1;
        if (beat_ix == LAST_BEAT) begin
          writing <= 1'b0;
        end
      end
      // read beats counted as they arrive
      if (reading && br_rd_data_valid) begin
        beat_ix <= beat_ix + 1'b1;
        if (beat_ix == LAST_BEAT) begin
          reading <= 1'b0;
        end
      end
      if (start_write) begin
        br_cmd  <= cmd_write;
        writing <= 1'b1;
        beat_ix <= '0;
      end else if (start_read) begin
        br_cmd  <= cmd_read;
        reading <= 1'b1;
        beat_ix <= '0;
      end
    end
  end

  // base address is payload, no reset
  always_ff @(posedge clk) begin
    if (start_write) begin
      br_addr <= ram_addr_t'(wb_base >> BEAT_SHIFT);
    end else if (start_read) begin
      br_addr <= ram_addr_t'(rd_base >> BEAT_SHIFT);
    end
  end

endmodule

// ==== dcache_ctrl.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// cache controller FSM
// sequences hits, write-back, line fetch and the final merge
// ~~~~~~~~~~~~~~~~~~~~
module dcache_ctrl (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 enable,
  input  dcache_pkg::byte_en_t write_enable_bytes,
  input  logic                 hit,
  input  logic                 victim_dirty,
  input  logic                 burst_done,
  input  logic                 br_rd_data_valid,
  input  dcache_pkg::word_t    rd_word,
  output logic                 busy,
  output dcache_pkg::word_t    data_out,
  output logic                 data_out_valid,
  output logic                 tag_fill,
  output logic                 mark_dirty,
  output logic                 word_we,
  output logic                 fill_we,
  output logic                 start_write,
  output logic                 start_read
);
  import dcache_pkg::*;

  cache_state_e state;

  logic accept;
  logic is_write;

  // handshake, request taken only while not busy
  assign accept   = enable && !busy;
  // any enabled byte makes it a write
  assign is_write = |write_enable_bytes;

  // strobes to the stores and the burst port
  always_comb begin
    tag_fill    = 1'b0;
    mark_dirty  = 1'b0;
    word_we     = 1'b0;
    fill_we     = 1'b0;
    start_write = 1'b0;
    start_read  = 1'b0;
    case (state)
      // merge cycle already has busy low, so it takes requests like idle
      st_idle, st_merge: begin
        if (accept) begin
          if (hit) begin
            word_we    = is_write;
            mark_dirty = is_write;
          end else if (victim_dirty) begin
            start_write = 1'b1;
          end else begin
            start_read = 1'b1;
            tag_fill   = 1'b1;
          end
        end
      end
      st_write_back: begin
        // evicted line is out, claim the line and fetch
        if (burst_done) begin
          start_read = 1'b1;
          tag_fill   = 1'b1;
        end
      end
      st_fetch_wait: begin
        fill_we = br_rd_data_valid;
      end
      st_fetch: begin
        fill_we = br_rd_data_valid;
        // request bytes go in with the last beat
        if (burst_done) begin
          word_we    = is_write;
          mark_dirty = is_write;
        end
      end
      default: begin
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state          <= st_idle;
      busy           <= 1'b0;
      data_out_valid <= 1'b0;
    end else begin
      // single cycle pulse
      data_out_valid <= 1'b0;
      case (state)
        st_idle, st_merge: begin
          state <= st_idle;
          if (accept) begin
            if (hit) begin
              if (!is_write) begin
                data_out       <= rd_word;
                data_out_valid <= 1'b1;
              end
            end else begin
              busy  <= 1'b1;
              state <= victim_dirty ? st_write_back : st_fetch_wait;
            end
          end
        end
        st_write_back: begin
          if (burst_done) begin
            state <= st_fetch_wait;
          end
        end
        st_fetch_wait: begin
          // RAM latency varies, first beat moves on
          if (br_rd_data_valid) begin
            state <= st_fetch;
          end
        end
        st_fetch: begin
          if (burst_done) begin
            // read word forwarded from the last beat if it lives there
            if (!is_write) begin
              data_out       <= rd_word;
              data_out_valid <= 1'b1;
            end
            busy  <= 1'b0;
            state <= st_merge;
          end
        end
        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

endmodule

// ==== dcache_line_store.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// line data array
// byte-enabled word write, beat fill and beat read for write-back
// ~~~~~~~~~~~~~~~~~~~~
module dcache_line_store #(
  parameter int LINE_IX_BITS = 1
) (
  input  logic                 clk,
  input  dcache_pkg::addr_t    address,
  input  logic                 word_we,
  input  dcache_pkg::byte_en_t byte_en,
  input  dcache_pkg::word_t    data_in,
  input  logic                 fill_we,
  input  dcache_pkg::beat_ix_t beat_ix,
  input  dcache_pkg::beat_t    fill_beat,
  output dcache_pkg::word_t    rd_word,
  output dcache_pkg::beat_t    rd_beat
);
  import dcache_pkg::*;

  localparam int LINE_COUNT     = 2 ** LINE_IX_BITS;
  localparam int WORDS_PER_LINE = 2 ** WORD_IX_BITS;
  // word select inside a beat
  localparam int HALF_BITS      = $clog2(WORDS_PER_BEAT);

  word_t mem [LINE_COUNT][WORDS_PER_LINE];

  logic [LINE_IX_BITS-1:0] line_ix;
  word_ix_t                word_ix;
  beat_ix_t                word_beat;
  logic [HALF_BITS-1:0]    word_half;

  assign line_ix   = address[OFFSET_BITS+WORD_IX_BITS +: LINE_IX_BITS];
  assign word_ix   = address[OFFSET_BITS +: WORD_IX_BITS];
  // beat k holds words 2k (low) and 2k+1 (high)
  assign word_beat = word_ix[WORD_IX_BITS-1:HALF_BITS];
  assign word_half = word_ix[HALF_BITS-1:0];

  always_ff @(posedge clk) begin
    if (fill_we) begin
      for (int i = 0; i < WORDS_PER_BEAT; i++) begin
        mem[line_ix][{beat_ix, i[HALF_BITS-1:0]}] <= fill_beat[i*WORD_BITS +: WORD_BITS];
      end
    end
    // written last so request bytes win over a beat landing on the same word
    if (word_we) begin
      for (int b = 0; b < WORD_BITS / 8; b++) begin
        if (byte_en[b]) begin
          mem[line_ix][word_ix][b*8 +: 8] <= data_in[b*8 +: 8];
        end
      end
    end
  end

  // addressed word, forwarded from the arriving beat when it covers it
  always_comb begin
    if (fill_we && (word_beat == beat_ix)) begin
      rd_word = fill_beat[word_half*WORD_BITS +: WORD_BITS];
    end else begin
      rd_word = mem[line_ix][word_ix];
    end
  end

  // write-back beat at the current beat index
  always_comb begin
    for (int i = 0; i < WORDS_PER_BEAT; i++) begin
      rd_beat[i*WORD_BITS +: WORD_BITS] = mem[line_ix][{beat_ix, i[HALF_BITS-1:0]}];
    end
  end

endmodule

// ==== dcache_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// data cache package
// address fields, word and beat types, controller and RAM command enums
// ~~~~~~~~~~~~~~~~~~~~
package dcache_pkg;

  // byte address width, 32 bit address space
  localparam int ADDR_BITS = 32;

  // cached word, a multiple of 8 bits
  localparam int WORD_BITS = 32;

  // words are 4 byte aligned, low 2 bits always zero
  localparam int OFFSET_BITS = 2;

  // 2^3 = 8 words per line
  localparam int WORD_IX_BITS = 3;

  // RAM side beat, two words wide
  localparam int BEAT_BITS = 64;
  localparam int WORDS_PER_BEAT = BEAT_BITS / WORD_BITS;

  // one burst moves exactly one line
  localparam int BEATS_PER_LINE = (2 ** WORD_IX_BITS) / WORDS_PER_BEAT;

  // 2^8 beats of 8 bytes = 2 KB of RAM
  localparam int RAM_ADDR_BITS = 8;

  typedef logic [ADDR_BITS-1:0] addr_t;
  typedef logic [WORD_BITS-1:0] word_t;
  typedef logic [WORD_BITS/8-1:0] byte_en_t;
  typedef logic [BEAT_BITS-1:0] beat_t;
  typedef logic [RAM_ADDR_BITS-1:0] ram_addr_t;
  typedef logic [WORD_IX_BITS-1:0] word_ix_t;
  typedef logic [$clog2(BEATS_PER_LINE)-1:0] beat_ix_t;

  // controller states
  // fetch_wait covers the RAM read latency, fetch takes the remaining beats
  typedef enum logic [2:0] {
    st_idle,
    st_write_back,
    st_fetch_wait,
    st_fetch,
    st_merge
  } cache_state_e;

  // burst RAM command, encoding fixed by the RAM
  typedef enum logic {
    cmd_read  = 1'b0,
    cmd_write = 1'b1
  } br_cmd_e;

endpackage

// ==== dcache_tag_store.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// tag store: valid, dirty and tag per line
// combinational hit lookup for the request address
// ~~~~~~~~~~~~~~~~~~~~
module dcache_tag_store #(
  parameter int LINE_IX_BITS = 1,
  localparam int TAG_BITS = dcache_pkg::ADDR_BITS - LINE_IX_BITS
                          - dcache_pkg::WORD_IX_BITS - dcache_pkg::OFFSET_BITS
) (
  input  logic                clk,
  input  logic                rst,
  input  dcache_pkg::addr_t   address,
  input  logic                tag_fill,
  input  logic                mark_dirty,
  output logic                hit,
  output logic                victim_dirty,
  output logic [TAG_BITS-1:0] victim_tag
);
  import dcache_pkg::*;

  localparam int LINE_COUNT = 2 ** LINE_IX_BITS;

  logic                line_valid [LINE_COUNT];
  logic                line_dirty [LINE_COUNT];
  logic [TAG_BITS-1:0] line_tag   [LINE_COUNT];

  // |tag|line|word|00|
  logic [LINE_IX_BITS-1:0] line_ix;
  logic [TAG_BITS-1:0]     req_tag;

  assign line_ix = address[OFFSET_BITS+WORD_IX_BITS +: LINE_IX_BITS];
  assign req_tag = address[ADDR_BITS-1 -: TAG_BITS];

  // lookup on the indexed line
  assign hit          = line_valid[line_ix] && (line_tag[line_ix] == req_tag);
  // dirty only ever set on a valid line
  assign victim_dirty = line_valid[line_ix] && line_dirty[line_ix];
  assign victim_tag   = line_tag[line_ix];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < LINE_COUNT; i++) begin
        line_valid[i] <= 1'b0;
        line_dirty[i] <= 1'b0;
      end
    end else if (tag_fill) begin
      // new line claimed when its fetch starts, clean until merged
      line_valid[line_ix] <= 1'b1;
      line_dirty[line_ix] <= 1'b0;
    end else if (mark_dirty) begin
      line_dirty[line_ix] <= 1'b1;
    end
  end

  // tag array itself carries no reset, valid bits guard it
  always_ff @(posedge clk) begin
    if (tag_fill) begin
      line_tag[line_ix] <= req_tag;
    end
  end

endmodule

// ==== dcache_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// write-back data cache top
// core request port on one side, 64 bit burst RAM on the other
// ~~~~~~~~~~~~~~~~~~~~
module dcache_top #(
  parameter int LINE_IX_BITS = 1
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  enable,
  input  dcache_pkg::addr_t     address,
  input  dcache_pkg::byte_en_t  write_enable_bytes,
  input  dcache_pkg::word_t     data_in,
  output dcache_pkg::word_t     data_out,
  output logic                  data_out_valid,
  output logic                  busy,
  output dcache_pkg::br_cmd_e   br_cmd,
  output logic                  br_cmd_en,
  output dcache_pkg::ram_addr_t br_addr,
  output dcache_pkg::beat_t     br_wr_data,
  input  dcache_pkg::beat_t     br_rd_data,
  input  logic                  br_rd_data_valid
);
  import dcache_pkg::*;

  localparam int TAG_BITS = ADDR_BITS - LINE_IX_BITS - WORD_IX_BITS - OFFSET_BITS;

  // tag store to controller and burst port
  logic                hit;
  logic                victim_dirty;
  logic [TAG_BITS-1:0] victim_tag;
  // controller strobes
  logic                tag_fill;
  logic                mark_dirty;
  logic                word_we;
  logic                fill_we;
  logic                start_write;
  logic                start_read;
  // line store and burst port
  word_t               rd_word;
  beat_t               rd_beat;
  beat_ix_t            beat_ix;
  logic                burst_done;

  dcache_tag_store #(
    .LINE_IX_BITS (LINE_IX_BITS)
  ) tag_store0 (
    .clk          (clk),
    .rst          (rst),
    .address      (address),
    .tag_fill     (tag_fill),
    .mark_dirty   (mark_dirty),
    .hit          (hit),
    .victim_dirty (victim_dirty),
    .victim_tag   (victim_tag)
  );

  // fill beats come directly off the RAM read bus
  dcache_line_store #(
    .LINE_IX_BITS (LINE_IX_BITS)
  ) line_store0 (
    .clk       (clk),
    .address   (address),
    .word_we   (word_we),
    .byte_en   (write_enable_bytes),
    .data_in   (data_in),
    .fill_we   (fill_we),
    .beat_ix   (beat_ix),
    .fill_beat (br_rd_data),
    .rd_word   (rd_word),
    .rd_beat   (rd_beat)
  );

  dcache_ctrl ctrl0 (
    .clk                (clk),
    .rst                (rst),
    .enable             (enable),
    .write_enable_bytes (write_enable_bytes),
    .hit                (hit),
    .victim_dirty       (victim_dirty),
    .burst_done         (burst_done),
    .br_rd_data_valid   (br_rd_data_valid),
    .rd_word            (rd_word),
    .busy               (busy),
    .data_out           (data_out),
    .data_out_valid     (data_out_valid),
    .tag_fill           (tag_fill),
    .mark_dirty         (mark_dirty),
    .word_we            (word_we),
    .fill_we            (fill_we),
    .start_write        (start_write),
    .start_read         (start_read)
  );

  dcache_burst_port #(
    .LINE_IX_BITS (LINE_IX_BITS)
  ) burst_port0 (
    .clk              (clk),
    .rst              (rst),
    .address          (address),
    .victim_tag       (victim_tag),
    .start_write      (start_write),
    .start_read       (start_read),
    .rd_beat          (rd_beat),
    .br_rd_data_valid (br_rd_data_valid),
    .beat_ix          (beat_ix),
    .burst_done       (burst_done),
    .br_cmd           (br_cmd),
    .br_cmd_en        (br_cmd_en),
    .br_addr          (br_addr),
    .br_wr_data       (br_wr_data)
  );

endmodule

// ==== tb_dcache.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// data cache testbench
// hits, misses and dirty eviction against a shadow memory
// ~~~~~~~~~~~~~~~~~~~~
module tb_dcache;
  import dcache_pkg::*;

  localparam int LINE_IX_BITS    = 1;
  localparam int CLK_PERIOD      = 100;
  localparam int DRIVE_DELAY     = 10;
  localparam int RESET_CYCLES    = 8;
  localparam int TEST_COUNT      = 6;
  localparam int CYCLES_PER_TEST = 200;
  localparam int CYCLE_LIMIT     = TEST_COUNT * CYCLES_PER_TEST;
  localparam int SHADOW_WORDS    = (2 ** RAM_ADDR_BITS) * WORDS_PER_BEAT;
  localparam int LINE_BYTES      = (2 ** WORD_IX_BITS) * (WORD_BITS / 8);

  logic      clk;
  logic      rst;
  logic      enable;
  addr_t     address;
  byte_en_t  write_enable_bytes;
  word_t     data_in;
  word_t     data_out;
  logic      data_out_valid;
  logic      busy;
  br_cmd_e   br_cmd;
  logic      br_cmd_en;
  ram_addr_t br_addr;
  beat_t     br_wr_data;
  beat_t     br_rd_data;
  logic      br_rd_data_valid;
  logic [2:0] ram_latency;

  // architectural memory contents as the core sees them
  word_t       shadow [SHADOW_WORDS];
  logic [31:0] lfsr_state;
  addr_t       pending_addr;
  addr_t       victim_base;
  ram_addr_t   wb_ptr;
  int          wb_left;
  int          errors;
  int          checks;
  int          tests_done;
  int          cycle_count;
  int          rd_bursts;
  int          wr_bursts;
  int          valid_count;
  int          rd_mark;
  int          wr_mark;
  int          valid_mark;
  int          error_mark;

  dcache_top #(
    .LINE_IX_BITS (LINE_IX_BITS)
  ) dut0 (
    .clk                (clk),
    .rst                (rst),
    .enable             (enable),
    .address            (address),
    .write_enable_bytes (write_enable_bytes),
    .data_in            (data_in),
    .data_out           (data_out),
    .data_out_valid     (data_out_valid),
    .busy               (busy),
    .br_cmd             (br_cmd),
    .br_cmd_en          (br_cmd_en),
    .br_addr            (br_addr),
    .br_wr_data         (br_wr_data),
    .br_rd_data         (br_rd_data),
    .br_rd_data_valid   (br_rd_data_valid)
  );

  burst_ram_model #(
    .DRIVE_DELAY (DRIVE_DELAY)
  ) ram0 (
    .clk              (clk),
    .br_cmd           (br_cmd),
    .br_cmd_en        (br_cmd_en),
    .br_addr          (br_addr),
    .br_wr_data       (br_wr_data),
    .latency          (ram_latency),
    .br_rd_data       (br_rd_data),
    .br_rd_data_valid (br_rd_data_valid)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // x^32 + x^22 + x^2 + x + 1 taps with one step per bit
  function automatic logic next_lfsr_bit();
    logic fb;
    fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] random_bits(input int count);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < count; i++) begin
      value = {value[30:0], next_lfsr_bit()};
    end
    return value;
  endfunction

  function automatic int shadow_ix(input addr_t a);
    return (a >> OFFSET_BITS) % SHADOW_WORDS;
  endfunction

  // beat k carries words 2k (low) and 2k+1 (high)
  function automatic beat_t shadow_beat(input ram_addr_t b);
    beat_t value;
    for (int w = 0; w < WORDS_PER_BEAT; w++) begin
      value[w*WORD_BITS +: WORD_BITS] = shadow[b*WORDS_PER_BEAT + w];
    end
    return value;
  endfunction

  function automatic ram_addr_t line_base_beat(input addr_t a);
    return ram_addr_t'((a & ~addr_t'(LINE_BYTES - 1)) >> 3);
  endfunction

  function automatic int total_errors();
    return errors + dut0.assertions0.fail_count;
  endfunction

  task automatic report_mismatch(input string name, input logic [63:0] exp, input logic [63:0] act);
    errors++;
    $display("Error %0t %s expected %h actual %h", $time, name, exp, act);
  endtask

  // sampled on the rising edge before the DUT flops update
  always @(posedge clk) begin
    if (!rst) begin
      if (data_out_valid) begin
        valid_count++;
        checks++;
        assert (data_out == shadow[shadow_ix(pending_addr)])
          else report_mismatch("data_out", shadow[shadow_ix(pending_addr)], data_out);
      end
      if (wb_left != 0) begin
        checks++;
        assert (br_wr_data == shadow_beat(wb_ptr))
          else report_mismatch("br_wr_data", shadow_beat(wb_ptr), br_wr_data);
        wb_ptr++;
        wb_left--;
      end
      if (br_cmd_en) begin
        checks++;
        if (br_cmd == cmd_write) begin
          wr_bursts++;
          checks++;
          assert (br_addr == line_base_beat(victim_base))
            else report_mismatch("br_addr", line_base_beat(victim_base), br_addr);
          assert (br_wr_data == shadow_beat(line_base_beat(victim_base)))
            else report_mismatch("br_wr_data", shadow_beat(line_base_beat(victim_base)),
                                 br_wr_data);
          wb_ptr  = line_base_beat(victim_base) + 1'b1;
          wb_left = BEATS_PER_LINE - 1;
        end else begin
          rd_bursts++;
          assert (br_addr == line_base_beat(pending_addr))
            else report_mismatch("br_addr", line_base_beat(pending_addr), br_addr);
        end
      end
    end
  end

  // one request held until the miss (if any) is over
  task automatic issue(input addr_t addr, input byte_en_t mask, input word_t data,
                       input bit hold);
    pending_addr = addr;
    ram_latency  = 3'(2 + random_bits(2));
    for (int b = 0; b < WORD_BITS / 8; b++) begin
      if (mask[b]) begin
        shadow[shadow_ix(addr)][b*8 +: 8] = data[b*8 +: 8];
      end
    end
    enable             = 1'b1;
    address            = addr;
    write_enable_bytes = mask;
    data_in            = data;
    @(posedge clk);
    #DRIVE_DELAY;
    // with hold the request stays up and must be ignored while busy
    if (!hold) begin
      enable = 1'b0;
    end
    while (busy) begin
      @(posedge clk);
      #DRIVE_DELAY;
    end
    enable = 1'b0;
    @(posedge clk);
    #DRIVE_DELAY;
  endtask

  task automatic finish_test(input string name, input int exp_rd, input int exp_wr,
                             input int exp_valid);
    checks += 3;
    assert (rd_bursts - rd_mark == exp_rd) else begin
      errors++;
      $display("%s saw %0d read bursts instead of %0d", name, rd_bursts - rd_mark, exp_rd);
    end
    assert (wr_bursts - wr_mark == exp_wr) else begin
      errors++;
      $display("%s saw %0d write bursts instead of %0d", name, wr_bursts - wr_mark, exp_wr);
    end
    assert (valid_count - valid_mark == exp_valid) else begin
      errors++;
      $display("%s saw %0d data_out_valid pulses instead of %0d", name,
               valid_count - valid_mark, exp_valid);
    end
    tests_done++;
    $display("test %0d %s: %s", tests_done, name,
             (total_errors() == error_mark) ? "passed" : "failed");
    rd_mark    = rd_bursts;
    wr_mark    = wr_bursts;
    valid_mark = valid_count;
    error_mark = total_errors();
  endtask

  initial begin
    cycle_count = 0;
    while (cycle_count < CYCLE_LIMIT) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("timeout: no result after %0d cycles", CYCLE_LIMIT);
    $display("RESULT: FAIL");
    $finish;
  end

  initial begin
    byte_en_t mask;
    word_t    wdata;
    rst                = 1'b1;
    enable             = 1'b0;
    address            = '0;
    write_enable_bytes = '0;
    data_in            = '0;
    ram_latency        = 3'd2;
    lfsr_state         = 32'd84679;
    pending_addr       = '0;
    victim_base        = '0;
    wb_ptr             = '0;
    wb_left            = 0;
    errors             = 0;
    checks             = 0;
    tests_done         = 0;
    rd_bursts          = 0;
    wr_bursts          = 0;
    valid_count        = 0;
    rd_mark            = 0;
    wr_mark            = 0;
    valid_mark         = 0;
    error_mark         = 0;
    for (int i = 0; i < SHADOW_WORDS; i++) begin
      shadow[i] = word_t'(i * 4) ^ 32'h5a5a_0000;
    end
    repeat (RESET_CYCLES) @(posedge clk);
    #DRIVE_DELAY;
    rst = 1'b0;

    issue(32'h104, 4'b0000, '0, 1'b0);
    finish_test("cold read miss", 1, 0, 1);

    // same line as the cold read
    issue(32'h118, 4'b0000, '0, 1'b0);
    finish_test("read hit", 0, 0, 1);

    mask = byte_en_t'(random_bits(4));
    if (mask == '0) begin
      mask = 4'b1001;
    end
    wdata = random_bits(32);
    issue(32'h108, mask, wdata, 1'b0);
    issue(32'h108, 4'b0000, '0, 1'b0);
    finish_test("write hit", 0, 0, 1);

    // new tag evicts the dirty line 0 and the old word comes back from RAM
    victim_base = 32'h100;
    issue(32'h50c, 4'b0000, '0, 1'b0);
    issue(32'h108, 4'b0000, '0, 1'b0);
    finish_test("dirty eviction", 2, 1, 2);

    mask = byte_en_t'(random_bits(4));
    if (mask == '0) begin
      mask = 4'b0110;
    end
    wdata = random_bits(32);
    issue(32'h2e4, mask, wdata, 1'b0);
    issue(32'h2e4, 4'b0000, '0, 1'b0);
    finish_test("write miss", 1, 0, 1);

    // line 1 was left dirty by the write miss
    victim_base = 32'h2e0;
    issue(32'h7a0, 4'b0000, '0, 1'b1);
    finish_test("request while busy", 1, 1, 1);

    $display("tests %0d, checks %0d, errors %0d", tests_done, checks, total_errors());
    if (total_errors() == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule
